// File: dv/sifhTb.sv
`timescale 1ns/100ps

module sifhTb;
    localparam int binAddrW = 6;
    localparam int countW = 16;
    localparam int tsW = 10;
    localparam int frameLen = 200;
    localparam int winHalf = 4;
    localparam int nBins = 2 ** binAddrW;
    localparam int lowW = tsW - binAddrW;
    localparam int clkPeriod = 40;
    localparam int quietCycles = 24;
    localparam int runCycles = 2 * frameLen * 4 + 4 * nBins + 50;
    localparam int watchdogCycles = 10 + 3 * (runCycles + quietCycles + 8);

    logic clk = 1'b0;
    logic res = 1'b0;
    logic start = 1'b0;
    logic [tsW-1:0] ts = '0;
    logic tsValid = 1'b0;
    logic tsReady;
    logic done;
    logic [binAddrW-1:0] coarseBin;
    logic [binAddrW-1:0] peakBin;
    logic [countW-1:0] peakCount;

    logic [31:0] rngState = 32'hf38d;
    int prevBin = 0;
    int gapLeft = 0;
    int center = 29; // cluster center of the current run
    bit driving = 1'b0;
    bit xferNext = 1'b0; // transfer happens at the coming edge
    int runBase = 0; // first captured entry of the current run
    bit readySeen = 1'b0; // tsReady was high in this run
    int firstPassLen = -1; // transfers taken before tsReady first fell
    logic [tsW-1:0] captured[$];

    int expCoarse;
    int expPeak;
    int expCount;

    sifhTop i_sifhTop (
        .clk(clk), .res(res), .start(start), .ts(ts), .tsValid(tsValid),
        .tsReady(tsReady), .done(done), .coarseBin(coarseBin),
        .peakBin(peakBin), .peakCount(peakCount)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [tsW-1:0] drawTimestamp();
        int bin;
        rngState = nextRandom(rngState);
        if (rngState[0]) begin
            bin = prevBin; // back-to-back repeat hits the forwarding path
        end else if (rngState[1]) begin
            bin = center + int'(rngState[7:4]) % 13 - 6;
            if (bin < 0) begin
                bin = 0;
            end
            if (bin > nBins - 1) begin
                bin = nBins - 1;
            end
        end else begin
            bin = int'(rngState[8 +: binAddrW]);
        end
        prevBin = bin;
        rngState = nextRandom(rngState);
        return {binAddrW'(bin), rngState[lowW-1:0]};
    endfunction

    task automatic stopOnFailure();
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkValue(input string name, input int expected, input int actual);
        assert (expected == actual)
        else begin
            $display("[ERROR] t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
            stopOnFailure();
        end
    endtask

    // reference histograms of the current run with the window on pass two
    task automatic computeModel();
        int hist1[nBins];
        int hist2[nBins];
        int bin;
        int lo;
        int hi;
        int i;
        logic [tsW-1:0] t;
        hist1 = '{default: 0};
        hist2 = '{default: 0};
        for (i = 0; i < frameLen; i++) begin
            t = captured[runBase + i];
            bin = int'(t >> lowW);
            hist1[bin]++;
        end
        expCoarse = 0;
        for (i = 1; i < nBins; i++) begin
            if (hist1[i] > hist1[expCoarse]) begin
                expCoarse = i; // first maximum wins ties
            end
        end
        lo = (expCoarse < winHalf) ? 0 : expCoarse - winHalf;
        hi = (expCoarse + winHalf > nBins - 1) ? nBins - 1 : expCoarse + winHalf;
        for (i = frameLen; i < 2 * frameLen; i++) begin
            t = captured[runBase + i];
            bin = int'(t >> lowW);
            if (bin >= lo && bin <= hi) begin
                hist2[bin]++;
            end
        end
        expPeak = 0;
        for (i = 1; i < nBins; i++) begin
            if (hist2[i] > hist2[expPeak]) begin
                expPeak = i;
            end
        end
        expCount = hist2[expPeak];
    endtask

    task automatic runFrame(input int runIdx);
        @(posedge clk);
        runBase = captured.size();
        readySeen = 1'b0;
        firstPassLen = -1;
        center = (runIdx == 0) ? 29 : ((runIdx == 1) ? 2 : nBins - 3); // edges test clamping
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        driving = 1'b1;
        while (captured.size() - runBase < frameLen / 2) begin
            @(posedge clk);
        end
        start <= 1'b1; // mid-run start that the DUT ignores
        @(posedge clk);
        start <= 1'b0;
        do begin
            @(negedge clk);
        end while (!done);
        driving = 1'b0;
        assert (firstPassLen >= 0)
        else begin
            $display("t=%0t tsReady never went low between the two passes", $time);
            stopOnFailure();
        end
        checkValue("firstPassLen", frameLen, firstPassLen);
        checkValue("transfers", 2 * frameLen, captured.size() - runBase);
        computeModel();
        checkValue("coarseBin", expCoarse, int'(coarseBin));
        checkValue("peakBin", expPeak, int'(peakBin));
        checkValue("peakCount", expCount, int'(peakCount));
        repeat (quietCycles) begin
            @(negedge clk);
            checkValue("done", 0, int'(done));
            checkValue("tsReady", 0, int'(tsReady));
        end
    endtask

    // timestamp source that holds ts until the transfer
    always @(posedge clk) begin
        if (!driving) begin
            tsValid <= 1'b0;
        end else if (!tsValid || xferNext) begin
            if (gapLeft > 0) begin
                tsValid <= 1'b0;
                gapLeft = gapLeft - 1;
            end else begin
                rngState = nextRandom(rngState);
                if (rngState[2:0] == 3'd0) begin
                    tsValid <= 1'b0; // gap of one to three cycles
                    gapLeft = int'(rngState[4:3]) % 3;
                end else begin
                    tsValid <= 1'b1;
                    ts <= drawTimestamp();
                end
            end
        end
    end

    // transfer monitor sampled mid-cycle
    always @(negedge clk) begin
        if (tsReady) begin
            readySeen = 1'b1;
        end else if (readySeen && firstPassLen < 0) begin
            firstPassLen = captured.size() - runBase; // end of the first frame
        end
        xferNext = tsValid && tsReady;
        if (xferNext) begin
            assert (captured.size() - runBase < 2 * frameLen)
            else begin
                $display("t=%0t more than two frames of timestamps were accepted", $time);
                stopOnFailure();
            end
            captured.push_back(ts);
        end
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("done never arrived within %0d cycles", watchdogCycles);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        repeat (10) @(posedge clk);
        res <= 1'b1;
        repeat (3) @(negedge clk);
        checkValue("tsReady", 0, int'(tsReady));
        checkValue("done", 0, int'(done));
        checkValue("coarseBin", 0, int'(coarseBin));
        checkValue("peakBin", 0, int'(peakBin));
        checkValue("peakCount", 0, int'(peakCount));
        for (int r = 0; r < 3; r++) begin
            runFrame(r);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the histogram engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sifhTop.f --top-module sifhTb -o sifhSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sifhSim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

// File: sifhTop.f
src/sifhPkg.sv
src/sramIf.sv
src/histSram.sv
src/histBuilder.sv
src/peakFinder.sv
src/sifhControl.sv
src/sifhTop.sv
dv/sifhTb.sv

// File: src/histBuilder.sv
`timescale 1ns/100ps

module histBuilder #(
    parameter int binAddrW = 6,
    parameter int countW = 16,
    parameter int tsW = 10,
    parameter int frameLen = 200
) (
    input logic clk,
    input logic res,
    input logic go,
    input sifhPkg::builderOp op,
    input logic filterEn,
    input logic [binAddrW-1:0] thLow,
    input logic [binAddrW-1:0] thHigh,
    input logic [tsW-1:0] ts,
    input logic tsValid,
    output logic tsReady,
    output logic done,
    sramIf.builder mem
);
    localparam int cntW = $clog2(frameLen + 1);
    localparam logic [binAddrW-1:0] lastBin = '1;

    logic busy;
    sifhPkg::builderOp mode;
    logic clearing;
    logic accumulating;
    logic [binAddrW-1:0] clrAddr;
    logic [cntW-1:0] taken; // transfers accepted this pass
    logic [binAddrW-1:0] tsBin;
    logic inWindow;
    logic accept;
    logic keep;
    logic s1Valid; // stage one read in flight
    logic [binAddrW-1:0] s1Bin;
    logic fwdValid; // a bin was written last cycle
    logic [binAddrW-1:0] fwdBin;
    logic [countW-1:0] fwdVal;
    logic [countW-1:0] baseVal;
    logic [countW-1:0] incVal;

    assign clearing = busy && mode == sifhPkg::opClear;
    assign accumulating = busy && mode == sifhPkg::opAccum;
    assign tsReady = accumulating && taken != cntW'(frameLen);
    assign tsBin = ts[tsW-1 -: binAddrW]; // upper bits select the bin
    assign inWindow = tsBin >= thLow && tsBin <= thHigh;
    assign accept = tsValid && tsReady;
    assign keep = accept && (!filterEn || inWindow); // dropped ones still count toward frameLen

    // stage one, read the current count
    assign mem.rdEn = keep;
    assign mem.rdAddr = tsBin;

    // stage two, the SRAM read missed last cycle's write to the same bin
    assign baseVal = (fwdValid && fwdBin == s1Bin) ? fwdVal : mem.rdData;
    assign incVal = baseVal + countW'(1);
    assign mem.wrEn = clearing || s1Valid;
    assign mem.wrAddr = clearing ? clrAddr : s1Bin;
    assign mem.wrData = clearing ? '0 : incVal;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            busy <= 1'b0;
            mode <= sifhPkg::opClear;
            clrAddr <= '0;
            taken <= '0;
            s1Valid <= 1'b0;
            fwdValid <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            s1Valid <= keep;
            fwdValid <= s1Valid;
            if (go) begin
                busy <= 1'b1;
                mode <= op;
                clrAddr <= '0;
                taken <= '0;
            end else if (clearing) begin
                clrAddr <= clrAddr + 1'b1;
                if (clrAddr == lastBin) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end else if (accumulating) begin
                if (accept) begin
                    taken <= taken + 1'b1;
                end
                // last accepted one is written at this edge
                if (taken == cntW'(frameLen)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        s1Bin <= tsBin;
        fwdBin <= s1Bin;
        fwdVal <= incVal;
    end

endmodule

// File: src/histSram.sv
`timescale 1ns/100ps

module histSram #(
    parameter int binAddrW = 6,
    parameter int countW = 16
) (
    input logic clk,
    sramIf.mem mem,
    input logic scanSel,
    input logic [binAddrW-1:0] scanAddr,
    input logic scanEn,
    output logic [countW-1:0] scanData
);
    localparam int depth = 2 ** binAddrW;

    logic [countW-1:0] ram [depth];
    logic [countW-1:0] rdReg;
    logic [binAddrW-1:0] rdAddrSel;
    logic rdEnSel;

    // scanner owns the read port during the peak phases
    assign rdAddrSel = scanSel ? scanAddr : mem.rdAddr;
    assign rdEnSel = scanSel ? scanEn : mem.rdEn;

    always_ff @(posedge clk) begin
        if (mem.wrEn) begin
            ram[mem.wrAddr] <= mem.wrData;
        end
        if (rdEnSel) begin
            rdReg <= ram[rdAddrSel]; // old data on same-address write
        end
    end

    assign mem.rdData = rdReg;
    assign scanData = rdReg;

endmodule

// File: src/peakFinder.sv
`timescale 1ns/100ps

module peakFinder #(
    parameter int binAddrW = 6,
    parameter int countW = 16
) (
    input logic clk,
    input logic res,
    input logic go,
    output logic [binAddrW-1:0] scanAddr,
    output logic scanEn,
    input logic [countW-1:0] scanData,
    output logic done,
    output logic [binAddrW-1:0] bestBin,
    output logic [countW-1:0] bestCount
);
    localparam logic [binAddrW-1:0] lastBin = '1;

    logic busy;
    logic rdValid; // scanData holds a bin this cycle
    logic [binAddrW-1:0] rdBin;

    assign scanEn = busy;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            busy <= 1'b0;
            scanAddr <= '0;
            rdValid <= 1'b0;
            rdBin <= '0;
            done <= 1'b0;
            bestBin <= '0;
            bestCount <= '0;
        end else begin
            rdValid <= busy;
            rdBin <= scanAddr;
            done <= rdValid && rdBin == lastBin; // two cycles after last address
            if (go) begin
                busy <= 1'b1;
                scanAddr <= '0;
                bestBin <= '0;
                bestCount <= '0;
            end else begin
                if (busy) begin
                    scanAddr <= scanAddr + 1'b1;
                    if (scanAddr == lastBin) begin
                        busy <= 1'b0;
                    end
                end
                // strict compare, ties keep the lower bin
                if (rdValid && scanData > bestCount) begin
                    bestBin <= rdBin;
                    bestCount <= scanData;
                end
            end
        end
    end

endmodule

// File: src/sifhControl.sv
`timescale 1ns/100ps

module sifhControl #(
    parameter int binAddrW = 6,
    parameter int countW = 16,
    parameter int winHalf = 4
) (
    input logic clk,
    input logic res,
    input logic start,
    output logic builderGo,
    output sifhPkg::builderOp builderOp,
    output logic filterEn,
    output logic [binAddrW-1:0] thLow,
    output logic [binAddrW-1:0] thHigh,
    input logic builderDone,
    output logic scanGo,
    output logic scanSel,
    input logic scanDone,
    input logic [binAddrW-1:0] scanBin,
    input logic [countW-1:0] scanCount,
    output logic done,
    output logic [binAddrW-1:0] coarseBin,
    output logic [binAddrW-1:0] peakBin,
    output logic [countW-1:0] peakCount
);
    localparam logic [binAddrW-1:0] lastBin = '1;

    sifhPkg::ctrlState state;
    logic [binAddrW-1:0] coarsePeak; // first-pass peak, shown at done
    logic [31:0] hiSum;
    logic [binAddrW-1:0] winLow;
    logic [binAddrW-1:0] winHigh;

    assign scanSel = state == sifhPkg::peak1 || state == sifhPkg::peak2;

    // window edges clamped to the bin range
    assign hiSum = 32'(coarsePeak) + 32'(winHalf);
    assign winLow = (32'(coarsePeak) < 32'(winHalf)) ? '0 : coarsePeak - binAddrW'(winHalf);
    assign winHigh = (hiSum > 32'(lastBin)) ? lastBin : hiSum[binAddrW-1:0];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= sifhPkg::idle;
            builderGo <= 1'b0;
            builderOp <= sifhPkg::opClear;
            filterEn <= 1'b0;
            thLow <= '0;
            thHigh <= '0;
            scanGo <= 1'b0;
            done <= 1'b0;
            coarsePeak <= '0;
            coarseBin <= '0;
            peakBin <= '0;
            peakCount <= '0;
        end else begin
            builderGo <= 1'b0;
            scanGo <= 1'b0;
            done <= 1'b0;
            case (state)
                sifhPkg::idle: begin
                    if (start) begin // start ignored elsewhere
                        state <= sifhPkg::clear1;
                        builderGo <= 1'b1;
                        builderOp <= sifhPkg::opClear;
                        filterEn <= 1'b0;
                    end
                end
                sifhPkg::clear1: begin
                    if (builderDone) begin
                        state <= sifhPkg::build1;
                        builderGo <= 1'b1;
                        builderOp <= sifhPkg::opAccum;
                    end
                end
                sifhPkg::build1: begin
                    if (builderDone) begin
                        state <= sifhPkg::peak1;
                        scanGo <= 1'b1;
                    end
                end
                sifhPkg::peak1: begin
                    if (scanDone) begin
                        coarsePeak <= scanBin;
                        state <= sifhPkg::window;
                    end
                end
                sifhPkg::window: begin
                    thLow <= winLow;
                    thHigh <= winHigh;
                    state <= sifhPkg::clear2;
                    builderGo <= 1'b1;
                    builderOp <= sifhPkg::opClear;
                end
                sifhPkg::clear2: begin
                    if (builderDone) begin
                        state <= sifhPkg::build2;
                        builderGo <= 1'b1;
                        builderOp <= sifhPkg::opAccum;
                        filterEn <= 1'b1; // second frame only counts inside window
                    end
                end
                sifhPkg::build2: begin
                    if (builderDone) begin
                        state <= sifhPkg::peak2;
                        scanGo <= 1'b1;
                    end
                end
                sifhPkg::peak2: begin
                    if (scanDone) begin
                        coarseBin <= coarsePeak;
                        peakBin <= scanBin;
                        peakCount <= scanCount;
                        done <= 1'b1;
                        state <= sifhPkg::idle;
                    end
                end
                default: state <= sifhPkg::idle;
            endcase
        end
    end

endmodule

// File: src/sifhPkg.sv
package sifhPkg;

    // top-level sequence, one state per phase of the two-pass run
    typedef enum logic [2:0] {
        idle,   // waiting for start
        clear1, // zero all bins before frame one
        build1, // count frame one, no filter
        peak1,  // coarse peak scan
        window, // clamp window around coarse peak
        clear2, // zero all bins before frame two
        build2, // count frame two inside window
        peak2   // refined peak scan
    } ctrlState;

    // command to the histogram builder, sampled together with go
    typedef enum logic {
        opClear, // write zero to every bin
        opAccum  // take frameLen timestamps and count them
    } builderOp;

endpackage

// File: src/sifhTop.sv
`timescale 1ns/100ps

// counts cannot overflow as long as frameLen stays below 2**countW
module sifhTop #(
    parameter int binAddrW = 6,
    parameter int countW = 16,
    parameter int tsW = 10,
    parameter int frameLen = 200,
    parameter int winHalf = 4
) (
    input logic clk,
    input logic res,
    input logic start,
    input logic [tsW-1:0] ts,
    input logic tsValid,
    output logic tsReady,
    output logic done,
    output logic [binAddrW-1:0] coarseBin,
    output logic [binAddrW-1:0] peakBin,
    output logic [countW-1:0] peakCount
);
    logic builderGo;
    sifhPkg::builderOp builderOp;
    logic filterEn;
    logic [binAddrW-1:0] thLow;
    logic [binAddrW-1:0] thHigh;
    logic builderDone;
    logic scanGo;
    logic scanSel;
    logic scanDone;
    logic [binAddrW-1:0] scanBin;
    logic [countW-1:0] scanCount;
    logic [binAddrW-1:0] scanAddr;
    logic scanEn;
    logic [countW-1:0] scanData;

    sramIf #(.binAddrW(binAddrW), .countW(countW)) sramBus ();

    histSram #(.binAddrW(binAddrW), .countW(countW)) i_histSram (
        .clk(clk), .mem(sramBus.mem), .scanSel(scanSel),
        .scanAddr(scanAddr), .scanEn(scanEn), .scanData(scanData)
    );

    histBuilder #(
        .binAddrW(binAddrW), .countW(countW), .tsW(tsW), .frameLen(frameLen)
    ) i_histBuilder (
        .clk(clk), .res(res), .go(builderGo), .op(builderOp),
        .filterEn(filterEn), .thLow(thLow), .thHigh(thHigh),
        .ts(ts), .tsValid(tsValid), .tsReady(tsReady),
        .done(builderDone), .mem(sramBus.builder)
    );

    peakFinder #(.binAddrW(binAddrW), .countW(countW)) i_peakFinder (
        .clk(clk), .res(res), .go(scanGo), .scanAddr(scanAddr), .scanEn(scanEn),
        .scanData(scanData), .done(scanDone), .bestBin(scanBin), .bestCount(scanCount)
    );

    sifhControl #(
        .binAddrW(binAddrW), .countW(countW), .winHalf(winHalf)
    ) i_sifhControl (
        .clk(clk), .res(res), .start(start),
        .builderGo(builderGo), .builderOp(builderOp), .filterEn(filterEn),
        .thLow(thLow), .thHigh(thHigh), .builderDone(builderDone),
        .scanGo(scanGo), .scanSel(scanSel), .scanDone(scanDone),
        .scanBin(scanBin), .scanCount(scanCount), .done(done),
        .coarseBin(coarseBin), .peakBin(peakBin), .peakCount(peakCount)
    );

endmodule

// File: src/sramIf.sv
`timescale 1ns/100ps

interface sramIf #(
    parameter int binAddrW = 6,
    parameter int countW = 16
);
    logic [binAddrW-1:0] rdAddr;
    logic rdEn;
    logic [countW-1:0] rdData; // registered, one cycle after rdEn
    logic [binAddrW-1:0] wrAddr;
    logic wrEn;
    logic [countW-1:0] wrData;

    modport builder (
        output rdAddr, rdEn, wrAddr, wrEn, wrData,
        input rdData
    );

    modport mem (
        input rdAddr, rdEn, wrAddr, wrEn, wrData,
        output rdData
    );
endinterface
